/* source/rv_frontend_macros.svh */
`ifndef RV_FRONTEND_MACROS_SVH
`define RV_FRONTEND_MACROS_SVH

// data path and address width
`define FE_XLEN 32

// first fetch address once reset is released
`define FE_RESET_PC 32'h8000_0000

// issued instructions remembered for operand forwarding
// newest entry maps to the newest select, every older one to the older select
`define FE_FWD_DEPTH 2

`endif

/* source/rv_frontend_pkg.sv */
`include "rv_frontend_macros.svh"

package rv_frontend_pkg;

  // word as it leaves the instruction bus
  typedef struct packed {
    logic [`FE_XLEN-1:0] pc;
    logic [31:0]         inst;
  } fetch_pkt_t;

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU,
    ALU_XOR, ALU_SRL, ALU_SRA, ALU_OR, ALU_AND,
    // csrrw passes rs1 straight through
    ALU_COPY
  } alu_op_e;

  typedef enum logic [1:0] {
    MEM_BYTE, MEM_HALF, MEM_WORD
  } mem_size_e;

  // source of the register write value
  typedef enum logic [1:0] {
    WB_ALU, WB_PC4, WB_UPC, WB_CSR
  } wb_sel_e;

  // operand source seen by execute
  typedef enum logic [1:0] {
    FWD_RF, FWD_NEW, FWD_OLD
  } fwd_sel_e;

  typedef struct packed {
    logic [`FE_XLEN-1:0] pc;
    logic [`FE_XLEN-1:0] imm;
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    alu_op_e             alu_op;
    wb_sel_e             wb_sel;
    logic                op2_imm;
    logic                branch;
    logic                jump;
    logic                reg_wen;
    logic                mem_ren;
    logic                mem_wen;
    mem_size_e           mem_size;
    logic                mem_sext;
    logic [11:0]         csr_addr;
    logic                csr_wen;
    logic                ecall;
    logic                ebreak;
    logic                mret;
    logic                fence_i;
    logic                illegal;
    fwd_sel_e            fwd1;
    fwd_sel_e            fwd2;
  } dec_pkt_t;

endpackage

/* source/pipe_stage.sv */
module pipe_stage #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clock,
  input  logic     reset,
  input  logic     flush,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data,
  input  logic     out_ready
);

  // a held entry can be replaced in the cycle it is taken
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;
    end
  end

  a_hold_stable: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> $stable(out_data));

endmodule

/* source/inst_fetch.sv */
`include "rv_frontend_macros.svh"

module inst_fetch (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        redirect_valid,
  input  logic [`FE_XLEN-1:0]         redirect_pc,
  input  logic [`FE_XLEN-1:0]         wb_dat_i,
  input  logic                        wb_ack,
  input  logic                        pkt_ready,
  output logic                        wb_cyc,
  output logic                        wb_stb,
  output logic [`FE_XLEN-1:0]         wb_adr,
  output logic                        pkt_valid,
  output rv_frontend_pkg::fetch_pkt_t pkt
);

  logic [`FE_XLEN-1:0] pc_q;
  logic                run_q;
  logic                busy_q;
  logic                drop_q;
  logic                start;

  // only one read is ever open, so a free fetch stage here stays free until its ack
  // run_q keeps the bus quiet through reset
  assign start = run_q && !busy_q && !drop_q && pkt_ready && !redirect_valid;

  // a redirect abandons the open read in the same cycle
  assign wb_cyc = start || (busy_q && !redirect_valid);
  assign wb_stb = wb_cyc;
  assign wb_adr = pc_q;

  // the acked word goes straight into the fetch stage register
  assign pkt_valid = wb_cyc && wb_ack;
  assign pkt.pc    = pc_q;
  assign pkt.inst  = wb_dat_i;

  always_ff @(posedge clock) begin
    if (reset) begin
      pc_q   <= `FE_RESET_PC;
      run_q  <= 1'b0;
      busy_q <= 1'b0;
      drop_q <= 1'b0;
    end else begin
      run_q  <= 1'b1;
      busy_q <= wb_cyc && !wb_ack;
      // an abandoned read still owes one ack, whose data is thrown away
      drop_q <= (drop_q || (redirect_valid && busy_q)) && !wb_ack;
      if (redirect_valid) begin
        pc_q <= redirect_pc;
      end else if (pkt_valid) begin
        pc_q <= pc_q + `FE_XLEN'd4;
      end
    end
  end

  a_stb_in_cyc: assert property (@(posedge clock) disable iff (reset)
    $rose(wb_stb) |-> wb_cyc);

endmodule

/* source/inst_decode.sv */
`include "rv_frontend_macros.svh"

module inst_decode (
  input  rv_frontend_pkg::fetch_pkt_t in_pkt,
  input  rv_frontend_pkg::fwd_sel_e   fwd1,
  input  rv_frontend_pkg::fwd_sel_e   fwd2,
  output rv_frontend_pkg::dec_pkt_t   out_pkt,
  output logic [4:0]                  src_rs1,
  output logic [4:0]                  src_rs2
);

  logic [31:0]               inst;
  logic [6:0]                opcode;
  logic [2:0]                funct3;
  logic [6:0]                funct7;
  logic                      is_lui, is_auipc, is_jal, is_jalr, is_branch;
  logic                      is_load, is_store, is_op_imm, is_op, is_csr;
  logic                      is_ecall, is_ebreak, is_mret, is_fence_i, legal;
  logic                      u_type, j_type, b_type, i_type, s_type;
  logic [`FE_XLEN-1:0]       imm;
  rv_frontend_pkg::alu_op_e  alu_op;
  rv_frontend_pkg::wb_sel_e  wb_sel;

  assign inst   = in_pkt.inst;
  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  // each class already rejects its reserved funct3 and funct7 codes
  assign is_lui     = opcode == 7'b01_101_11;
  assign is_auipc   = opcode == 7'b00_101_11;
  assign is_jal     = opcode == 7'b11_011_11;
  assign is_jalr    = opcode == 7'b11_001_11 && funct3 == 3'b000;
  assign is_branch  = opcode == 7'b11_000_11 && funct3[2:1] != 2'b01;
  assign is_load    = opcode == 7'b00_000_11 && funct3 != 3'b011 && funct3[2:1] != 2'b11;
  assign is_store   = opcode == 7'b01_000_11 && !funct3[2] && funct3[1:0] != 2'b11;
  assign is_op_imm  = opcode == 7'b00_100_11 &&
                      (funct3 == 3'b001 ? funct7 == 7'b0000000 :
                       funct3 == 3'b101 ? (funct7 & 7'b1011111) == 7'b0000000 : 1'b1);
  // rv32m encodings (funct7 0000001) fall through to illegal
  assign is_op      = opcode == 7'b01_100_11 &&
                      (funct7 == 7'b0000000 ||
                       (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
  assign is_csr     = opcode == 7'b11_100_11 && !funct3[2] && funct3[1:0] != 2'b00;
  assign is_ecall   = inst == 32'h0000_0073;
  assign is_ebreak  = inst == 32'h0010_0073;
  assign is_mret    = inst == 32'h3020_0073;
  assign is_fence_i = opcode == 7'b00_011_11 && funct3 == 3'b001;

  assign legal = is_lui || is_auipc || is_jal || is_jalr || is_branch || is_load ||
                 is_store || is_op_imm || is_op || is_csr || is_ecall || is_ebreak ||
                 is_mret || is_fence_i;

  // immediate formats
  assign u_type = is_lui || is_auipc;
  assign j_type = is_jal;
  assign b_type = is_branch;
  assign i_type = is_jalr || is_load || is_op_imm || is_csr;
  assign s_type = is_store;

  assign imm = (u_type ? {inst[31:12], 12'b0} : '0) |
               (j_type ? {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0} : '0) |
               (b_type ? {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0} : '0) |
               (i_type ? {{20{inst[31]}}, inst[31:20]} : '0) |
               (s_type ? {{20{inst[31]}}, inst[31:25], inst[11:7]} : '0);

  // lui adds its immediate to x0, csrrw adds zero to rs1
  assign src_rs1 = is_lui ? 5'd0 : inst[19:15];
  assign src_rs2 = (is_csr && funct3[1:0] == 2'b01) ? 5'd0 : inst[24:20];

  always_comb begin
    alu_op = rv_frontend_pkg::ALU_ADD;
    if (is_op || is_op_imm) begin
      case (funct3)
        3'b000:  alu_op = (is_op && funct7[5]) ? rv_frontend_pkg::ALU_SUB
                                               : rv_frontend_pkg::ALU_ADD;
        3'b001:  alu_op = rv_frontend_pkg::ALU_SLL;
        3'b010:  alu_op = rv_frontend_pkg::ALU_SLT;
        3'b011:  alu_op = rv_frontend_pkg::ALU_SLTU;
        3'b100:  alu_op = rv_frontend_pkg::ALU_XOR;
        3'b101:  alu_op = funct7[5] ? rv_frontend_pkg::ALU_SRA : rv_frontend_pkg::ALU_SRL;
        3'b110:  alu_op = rv_frontend_pkg::ALU_OR;
        default: alu_op = rv_frontend_pkg::ALU_AND;
      endcase
    end else if (is_branch) begin
      // beq/bne test the difference, the rest compare
      case (funct3[2:1])
        2'b00:   alu_op = rv_frontend_pkg::ALU_SUB;
        2'b10:   alu_op = rv_frontend_pkg::ALU_SLT;
        default: alu_op = rv_frontend_pkg::ALU_SLTU;
      endcase
    end else if (is_csr) begin
      case (funct3[1:0])
        2'b01:   alu_op = rv_frontend_pkg::ALU_COPY;
        2'b10:   alu_op = rv_frontend_pkg::ALU_OR;
        default: alu_op = rv_frontend_pkg::ALU_AND;
      endcase
    end
  end

  always_comb begin
    wb_sel = rv_frontend_pkg::WB_ALU;
    if (is_jal || is_jalr) begin
      wb_sel = rv_frontend_pkg::WB_PC4;
    end else if (is_auipc) begin
      wb_sel = rv_frontend_pkg::WB_UPC;
    end else if (is_csr) begin
      wb_sel = rv_frontend_pkg::WB_CSR;
    end
  end

  // an unmatched word ends up with every write and memory flag low
  always_comb begin
    out_pkt          = '0;
    out_pkt.pc       = in_pkt.pc;
    out_pkt.imm      = imm;
    out_pkt.rs1      = src_rs1;
    out_pkt.rs2      = src_rs2;
    out_pkt.rd       = inst[11:7];
    out_pkt.alu_op   = alu_op;
    out_pkt.wb_sel   = wb_sel;
    out_pkt.op2_imm  = is_lui || is_jalr || is_load || is_op_imm || is_store;
    out_pkt.branch   = is_branch;
    out_pkt.jump     = is_jal || is_jalr;
    out_pkt.reg_wen  = u_type || is_jal || is_jalr || is_load || is_op_imm || is_op || is_csr;
    out_pkt.mem_ren  = is_load;
    out_pkt.mem_wen  = is_store;
    out_pkt.mem_size = rv_frontend_pkg::MEM_WORD;
    if ((is_load || is_store) && funct3[1:0] == 2'b00) begin
      out_pkt.mem_size = rv_frontend_pkg::MEM_BYTE;
    end else if ((is_load || is_store) && funct3[1:0] == 2'b01) begin
      out_pkt.mem_size = rv_frontend_pkg::MEM_HALF;
    end
    out_pkt.mem_sext = is_load && !funct3[2];
    out_pkt.csr_addr = is_csr ? inst[31:20] : 12'd0;
    out_pkt.csr_wen  = is_csr;
    out_pkt.ecall    = is_ecall;
    out_pkt.ebreak   = is_ebreak;
    out_pkt.mret     = is_mret;
    out_pkt.fence_i  = is_fence_i;
    out_pkt.illegal  = !legal;
    out_pkt.fwd1     = fwd1;
    out_pkt.fwd2     = fwd2;
  end

endmodule

/* source/hazard_track.sv */
`include "rv_frontend_macros.svh"

module hazard_track (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      flush,
  input  logic                      issue,
  input  logic [4:0]                issue_rd,
  input  logic                      issue_wen,
  input  logic                      issue_load,
  input  logic [4:0]                src_rs1,
  input  logic [4:0]                src_rs2,
  input  logic                      src_valid,
  output logic                      stall,
  output rv_frontend_pkg::fwd_sel_e fwd1,
  output rv_frontend_pkg::fwd_sel_e fwd2
);

  localparam int DEPTH = `FE_FWD_DEPTH;

  typedef struct packed {
    logic [4:0] rd;
    logic       wen;
    logic       load;
  } hist_t;

  // entry 0 is the newest issued instruction
  hist_t [DEPTH-1:0] hist_q;
  logic              load_hit;

  // scan oldest first so the newest match is the one kept
  function automatic rv_frontend_pkg::fwd_sel_e pick(input hist_t [DEPTH-1:0] h,
                                                     input logic [4:0] src);
    rv_frontend_pkg::fwd_sel_e sel;
    sel = rv_frontend_pkg::FWD_RF;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (src != 5'd0 && h[i].wen && h[i].rd == src) begin
        sel = (i == 0) ? rv_frontend_pkg::FWD_NEW : rv_frontend_pkg::FWD_OLD;
      end
    end
    return sel;
  endfunction

  assign fwd1 = pick(hist_q, src_rs1);
  assign fwd2 = pick(hist_q, src_rs2);

  assign load_hit = hist_q[0].load && hist_q[0].wen && hist_q[0].rd != 5'd0 &&
                    (hist_q[0].rd == src_rs1 || hist_q[0].rd == src_rs2);
  assign stall    = src_valid && load_hit;

  always_ff @(posedge clock) begin
    if (reset || flush) begin
      hist_q <= '0;
    end else if (issue) begin
      hist_q <= {hist_q[DEPTH-2:0], hist_t'{rd: issue_rd, wen: issue_wen, load: issue_load}};
    end else if (stall) begin
      // one held cycle gives the load its bubble and its result then forwards normally
      hist_q[0].load <= 1'b0;
    end
  end

  a_stall_needs_src: assert property (@(posedge clock) disable iff (reset)
    !src_valid |-> !stall);

endmodule

/* source/rv_frontend.sv */
`include "rv_frontend_macros.svh"

module rv_frontend (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      redirect_valid,
  input  logic [`FE_XLEN-1:0]       redirect_pc,
  output logic                      wb_cyc,
  output logic                      wb_stb,
  output logic [`FE_XLEN-1:0]       wb_adr,
  input  logic [`FE_XLEN-1:0]       wb_dat_i,
  input  logic                      wb_ack,
  output logic                      out_valid,
  output rv_frontend_pkg::dec_pkt_t out_pkt,
  input  logic                      out_ready
);

  rv_frontend_pkg::fetch_pkt_t f_pkt, fs_pkt;
  rv_frontend_pkg::dec_pkt_t   d_pkt;
  rv_frontend_pkg::fwd_sel_e   fwd1, fwd2;
  logic                        f_valid, f_ready, fs_valid, fs_ready;
  logic                        ds_in_valid, ds_in_ready, stall;
  logic [4:0]                  src_rs1, src_rs2;

  // a load-use stall keeps the instruction in the fetch stage
  assign ds_in_valid = fs_valid && !stall;
  assign fs_ready    = ds_in_ready && !stall;

  inst_fetch fetch_i (
    .clock, .reset, .redirect_valid, .redirect_pc,
    .wb_dat_i, .wb_ack, .pkt_ready(f_ready),
    .wb_cyc, .wb_stb, .wb_adr, .pkt_valid(f_valid), .pkt(f_pkt)
  );

  pipe_stage #(.payload_t(rv_frontend_pkg::fetch_pkt_t)) fetch_stage_i (
    .clock, .reset, .flush(redirect_valid),
    .in_valid(f_valid), .in_data(f_pkt), .in_ready(f_ready),
    .out_valid(fs_valid), .out_data(fs_pkt), .out_ready(fs_ready)
  );

  inst_decode decode_i (
    .in_pkt(fs_pkt), .fwd1, .fwd2, .out_pkt(d_pkt), .src_rs1, .src_rs2
  );

  hazard_track hazard_i (
    .clock, .reset, .flush(redirect_valid), .issue(ds_in_valid && ds_in_ready),
    .issue_rd(d_pkt.rd), .issue_wen(d_pkt.reg_wen), .issue_load(d_pkt.mem_ren),
    .src_rs1, .src_rs2, .src_valid(fs_valid), .stall, .fwd1, .fwd2
  );

  pipe_stage #(.payload_t(rv_frontend_pkg::dec_pkt_t)) decode_stage_i (
    .clock, .reset, .flush(redirect_valid),
    .in_valid(ds_in_valid), .in_data(d_pkt), .in_ready(ds_in_ready),
    .out_valid, .out_data(out_pkt), .out_ready
  );

endmodule

/* dv/decode_model.svh */
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// expected decode of one word, fwd selects are filled in by the caller
function automatic rv_frontend_pkg::dec_pkt_t model_decode(input logic [31:0] pc,
                                                           input logic [31:0] w);
  rv_frontend_pkg::dec_pkt_t base;
  rv_frontend_pkg::dec_pkt_t p;
  rv_frontend_pkg::alu_op_e  op_by_f3 [8];
  logic [2:0]                f3;
  logic [31:0]               i_imm;
  logic                      ok;
  op_by_f3 = '{rv_frontend_pkg::ALU_ADD, rv_frontend_pkg::ALU_SLL, rv_frontend_pkg::ALU_SLT,
               rv_frontend_pkg::ALU_SLTU, rv_frontend_pkg::ALU_XOR, rv_frontend_pkg::ALU_SRL,
               rv_frontend_pkg::ALU_OR, rv_frontend_pkg::ALU_AND};
  f3 = w[14:12];
  i_imm = {{20{w[31]}}, w[31:20]};
  // what an unmatched word still carries
  base = '0;
  base.pc = pc;
  base.rs1 = w[19:15];
  base.rs2 = w[24:20];
  base.rd = w[11:7];
  base.mem_size = rv_frontend_pkg::MEM_WORD;
  p = base;
  ok = 1'b0;
  case (w[6:0])
    7'h37: begin
      ok = 1'b1;
      p.rs1 = 5'd0;
      p.imm = {w[31:12], 12'b0};
      p.op2_imm = 1'b1;
      p.reg_wen = 1'b1;
    end
    7'h17: begin
      ok = 1'b1;
      p.imm = {w[31:12], 12'b0};
      p.wb_sel = rv_frontend_pkg::WB_UPC;
      p.reg_wen = 1'b1;
    end
    7'h6f: begin
      ok = 1'b1;
      p.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      p.jump = 1'b1;
      p.reg_wen = 1'b1;
      p.wb_sel = rv_frontend_pkg::WB_PC4;
    end
    7'h67: begin
      ok = f3 == 3'd0;
      p.imm = i_imm;
      p.op2_imm = 1'b1;
      p.jump = 1'b1;
      p.reg_wen = 1'b1;
      p.wb_sel = rv_frontend_pkg::WB_PC4;
    end
    7'h63: begin
      ok = f3 != 3'd2 && f3 != 3'd3;
      p.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
      p.branch = 1'b1;
      p.alu_op = !f3[2] ? rv_frontend_pkg::ALU_SUB :
                 f3[1] ? rv_frontend_pkg::ALU_SLTU : rv_frontend_pkg::ALU_SLT;
    end
    7'h03: begin
      ok = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
      p.imm = i_imm;
      p.op2_imm = 1'b1;
      p.reg_wen = 1'b1;
      p.mem_ren = 1'b1;
      p.mem_size = rv_frontend_pkg::mem_size_e'(f3[1:0]);
      p.mem_sext = !f3[2];
    end
    7'h23: begin
      ok = f3 inside {3'd0, 3'd1, 3'd2};
      p.imm = {{20{w[31]}}, w[31:25], w[11:7]};
      p.op2_imm = 1'b1;
      p.mem_wen = 1'b1;
      p.mem_size = rv_frontend_pkg::mem_size_e'(f3[1:0]);
    end
    7'h13: begin
      ok = (f3 != 3'd1 || w[31:25] == 7'h00) &&
           (f3 != 3'd5 || w[31:25] inside {7'h00, 7'h20});
      p.imm = i_imm;
      p.op2_imm = 1'b1;
      p.reg_wen = 1'b1;
      p.alu_op = (f3 == 3'd5 && w[30]) ? rv_frontend_pkg::ALU_SRA : op_by_f3[f3];
    end
    7'h33: begin
      ok = w[31:25] == 7'h00 || (w[31:25] == 7'h20 && f3 inside {3'd0, 3'd5});
      p.reg_wen = 1'b1;
      p.alu_op = !w[30] ? op_by_f3[f3] :
                 (f3 == 3'd0) ? rv_frontend_pkg::ALU_SUB : rv_frontend_pkg::ALU_SRA;
    end
    7'h73: begin
      if (f3 == 3'd0) begin
        // only the three exact system words
        p.ecall = w == 32'h0000_0073;
        p.ebreak = w == 32'h0010_0073;
        p.mret = w == 32'h3020_0073;
        ok = p.ecall || p.ebreak || p.mret;
      end else begin
        ok = !f3[2];
        p.imm = i_imm;
        p.reg_wen = 1'b1;
        p.csr_wen = 1'b1;
        p.csr_addr = w[31:20];
        p.wb_sel = rv_frontend_pkg::WB_CSR;
        p.rs2 = (f3 == 3'd1) ? 5'd0 : w[24:20];
        p.alu_op = (f3 == 3'd1) ? rv_frontend_pkg::ALU_COPY :
                   (f3 == 3'd2) ? rv_frontend_pkg::ALU_OR : rv_frontend_pkg::ALU_AND;
      end
    end
    7'h0f: begin
      ok = f3 == 3'd1;
      p.fence_i = 1'b1;
    end
    default: begin
      ok = 1'b0;
    end
  endcase
  if (!ok) begin
    p = base;
  end
  p.illegal = !ok;
  return p;
endfunction

`endif

/* dv/tb_rv_frontend.sv */
`include "rv_frontend_macros.svh"

module tb_rv_frontend;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD     = 4;
  localparam int NUM_PKTS       = 2000;
  localparam int CYCLES_PER_PKT = 20;
  localparam int MEM_WORDS      = 256;
  localparam logic [6:0] OPCODES [11] = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03,
                                          7'h23, 7'h13, 7'h33, 7'h73, 7'h0f};
  localparam logic [31:0] SYS_WORDS [4] = '{32'h0000_0073, 32'h0010_0073,
                                            32'h3020_0073, 32'h0000_100f};
  localparam logic [6:0] F7_CHOICES [3] = '{7'h00, 7'h20, 7'h01};

  logic                      clock = 1'b0;
  logic                      reset = 1'b1;
  logic                      redirect_valid = 1'b0;
  logic [`FE_XLEN-1:0]       redirect_pc = '0;
  logic [`FE_XLEN-1:0]       wb_dat_i = '0;
  logic                      wb_ack = 1'b0;
  logic                      out_ready = 1'b0;
  logic                      wb_cyc, wb_stb, out_valid;
  logic [`FE_XLEN-1:0]       wb_adr;
  rv_frontend_pkg::dec_pkt_t out_pkt;

  logic [31:0]               mem [MEM_WORDS];
  logic                      mem_busy = 1'b0;
  int                        mem_wait = 0;
  logic [`FE_XLEN-1:0]       req_adr = '0;
  logic [`FE_XLEN-1:0]       exp_pc = `FE_RESET_PC;
  logic [4:0]                hist_rd [2];
  logic [1:0]                hist_wen = '0;
  rv_frontend_pkg::dec_pkt_t held_pkt;
  logic                      held_valid = 1'b0;
  int                        accepted = 0;

  `include "decode_model.svh"

  rv_frontend dut_i (
    .clock, .reset, .redirect_valid, .redirect_pc,
    .wb_cyc, .wb_stb, .wb_adr, .wb_dat_i, .wb_ack,
    .out_valid, .out_pkt, .out_ready
  );

  // small register numbers so that hazards come up often
  function automatic logic [31:0] random_word();
    logic [31:0] w;
    int          pick;
    w = $urandom;
    pick = $urandom_range(0, 15);
    if (pick == 0) begin
      w = SYS_WORDS[$urandom_range(0, 3)];
    end else if (pick > 1) begin
      w[6:0]   = OPCODES[$urandom_range(0, 10)];
      w[11:7]  = 5'($urandom_range(0, 3));
      w[19:15] = 5'($urandom_range(0, 3));
      w[24:20] = 5'($urandom_range(0, 3));
      if ($urandom_range(0, 3) != 0) begin
        w[31:25] = F7_CHOICES[$urandom_range(0, 2)];
      end
    end
    return w;
  endfunction

  // every address bit takes part in picking the table entry
  function automatic logic [31:0] mem_word(input logic [`FE_XLEN-1:0] adr);
    return mem[adr[9:2] ^ adr[17:10] ^ adr[25:18] ^ {adr[31:26], adr[1:0]}];
  endfunction

  function automatic rv_frontend_pkg::fwd_sel_e expect_fwd(input logic [4:0] src);
    if (src == 5'd0) return rv_frontend_pkg::FWD_RF;
    if (hist_wen[0] && hist_rd[0] == src) return rv_frontend_pkg::FWD_NEW;
    if (hist_wen[1] && hist_rd[1] == src) return rv_frontend_pkg::FWD_OLD;
    return rv_frontend_pkg::FWD_RF;
  endfunction

  task automatic abort_run(input string why);
    $display("%s at %0t", why, $time);
    $display("Test failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[ERROR] %0t %s expected %h actual %h", $time, name, exp, act);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic compare_pc(input string name, input logic [`FE_XLEN-1:0] exp,
                            input logic [`FE_XLEN-1:0] act);
    check_field(name, exp, act);
  endtask

  task automatic compare_pkt(input rv_frontend_pkg::dec_pkt_t exp,
                             input rv_frontend_pkg::dec_pkt_t act);
    check_field("out_pkt.pc", exp.pc, act.pc);
    check_field("out_pkt.imm", exp.imm, act.imm);
    check_field("out_pkt.rs1", 32'(exp.rs1), 32'(act.rs1));
    check_field("out_pkt.rs2", 32'(exp.rs2), 32'(act.rs2));
    check_field("out_pkt.rd", 32'(exp.rd), 32'(act.rd));
    check_field("out_pkt.alu_op", 32'(exp.alu_op), 32'(act.alu_op));
    check_field("out_pkt.wb_sel", 32'(exp.wb_sel), 32'(act.wb_sel));
    check_field("out_pkt.op2_imm", 32'(exp.op2_imm), 32'(act.op2_imm));
    check_field("out_pkt.branch", 32'(exp.branch), 32'(act.branch));
    check_field("out_pkt.jump", 32'(exp.jump), 32'(act.jump));
    check_field("out_pkt.reg_wen", 32'(exp.reg_wen), 32'(act.reg_wen));
    check_field("out_pkt.mem_ren", 32'(exp.mem_ren), 32'(act.mem_ren));
    check_field("out_pkt.mem_wen", 32'(exp.mem_wen), 32'(act.mem_wen));
    check_field("out_pkt.mem_size", 32'(exp.mem_size), 32'(act.mem_size));
    check_field("out_pkt.mem_sext", 32'(exp.mem_sext), 32'(act.mem_sext));
    check_field("out_pkt.csr_addr", 32'(exp.csr_addr), 32'(act.csr_addr));
    check_field("out_pkt.csr_wen", 32'(exp.csr_wen), 32'(act.csr_wen));
    check_field("out_pkt.ecall", 32'(exp.ecall), 32'(act.ecall));
    check_field("out_pkt.ebreak", 32'(exp.ebreak), 32'(act.ebreak));
    check_field("out_pkt.mret", 32'(exp.mret), 32'(act.mret));
    check_field("out_pkt.fence_i", 32'(exp.fence_i), 32'(act.fence_i));
    check_field("out_pkt.illegal", 32'(exp.illegal), 32'(act.illegal));
    check_field("out_pkt.fwd1", 32'(exp.fwd1), 32'(act.fwd1));
    check_field("out_pkt.fwd2", 32'(exp.fwd2), 32'(act.fwd2));
  endtask

  initial begin
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  initial begin
    void'($urandom(32'ha2b9));
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = random_word();
    end
    repeat (3) @(posedge clock);
    reset <= 1'b0;
    wait (accepted == NUM_PKTS);
    @(posedge clock);
    $display("Test passed");
    $finish;
  end

  initial begin
    #(NUM_PKTS * CYCLES_PER_PKT * CLK_PERIOD);
    $display("Timeout: the pipeline made no progress, %0d of %0d packets accepted",
             accepted, NUM_PKTS);
    $display("Test failed");
    $fatal(1, "watchdog expired");
  end

  // back-pressure and rare redirects to aligned targets
  always @(posedge clock) begin
    if (!reset) begin
      out_ready      <= $urandom_range(0, 3) != 0;
      redirect_valid <= $urandom_range(0, 63) == 0;
      redirect_pc    <= `FE_RESET_PC + (32'($urandom_range(0, MEM_WORDS - 1)) << 2);
    end
  end

  // Wishbone slave that still acks an abandoned read
  always @(posedge clock) begin
    if (reset) begin
      mem_busy <= 1'b0;
      wb_ack   <= 1'b0;
    end else if (wb_ack) begin
      wb_ack   <= 1'b0;
      mem_busy <= 1'b0;
    end else if (mem_busy) begin
      if (mem_wait == 0) begin
        wb_ack   <= 1'b1;
        wb_dat_i <= mem_word(req_adr);
      end else begin
        mem_wait <= mem_wait - 1;
      end
    end else if (wb_cyc && wb_stb) begin
      mem_busy <= 1'b1;
      req_adr  <= wb_adr;
      mem_wait <= $urandom_range(0, 3);
    end
  end

  always @(posedge clock) begin
    rv_frontend_pkg::dec_pkt_t exp_pkt;
    if (!reset) begin
      if (wb_stb && !wb_cyc) begin
        abort_run("wb_stb was high while wb_cyc was low");
      end
      if (mem_busy && wb_cyc) begin
        compare_pc("wb_adr", req_adr, wb_adr);
      end
      // a stalled output must not change
      if (held_valid && out_valid) begin
        compare_pkt(held_pkt, out_pkt);
      end
      held_valid = out_valid && !out_ready;
      held_pkt = out_pkt;
      if (out_valid && out_ready) begin
        exp_pkt = model_decode(exp_pc, mem_word(exp_pc));
        exp_pkt.fwd1 = expect_fwd(exp_pkt.rs1);
        exp_pkt.fwd2 = expect_fwd(exp_pkt.rs2);
        compare_pc("out_pkt.pc", exp_pc, out_pkt.pc);
        compare_pkt(exp_pkt, out_pkt);
        hist_rd[1] = hist_rd[0];
        hist_wen[1] = hist_wen[0];
        hist_rd[0] = exp_pkt.rd;
        hist_wen[0] = exp_pkt.reg_wen;
        exp_pc = exp_pc + 4;
        accepted++;
      end
      // everything in flight is dropped along with the forwarding history
      if (redirect_valid) begin
        hist_wen = '0;
        exp_pc = redirect_pc;
      end
    end
  end

endmodule

/* compile.f */
+incdir+source
+incdir+dv
source/rv_frontend_pkg.sv
source/pipe_stage.sv
source/inst_fetch.sv
source/inst_decode.sv
source/hazard_track.sv
source/rv_frontend.sv
dv/tb_rv_frontend.sv

/* Makefile */
# Verilator flow for the RV32I front end
VERILATOR  ?= verilator
TOP        ?= tb_rv_frontend
RTL_TOP    ?= rv_frontend
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Test passed
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
